//--- Makefile
TOOL = verilator
FLAGS = --timing --assert --timescale 1ns/1ps
TOP = spi_tb
FILE_LIST = flist.f
BUILD_DIR = obj_dir

.PHONY: lint sim clean

lint:
	$(TOOL) --lint-only $(FLAGS) --top-module $(TOP) -f $(FILE_LIST)

sim:
	$(TOOL) --binary $(FLAGS) --top-module $(TOP) -f $(FILE_LIST) \
		--Mdir $(BUILD_DIR) -o $(TOP)
	./$(BUILD_DIR)/$(TOP)

clean:
	rm -rf $(BUILD_DIR)

//--- flist.f
+incdir+rtl
rtl/spi_pkg.sv
rtl/spi_bus_if.sv
rtl/spi_peripheral.sv
rtl/spi_subperipheral_selector.sv
rtl/spi_scratch_register.sv
rtl/spi_readback_mux.sv
rtl/spi_top.sv
test/spi_tb.sv

//--- rtl/spi_bus_if.sv
////////////////////////////////////////
// SPI transaction bus
////////////////////////////////////////

`timescale 1ns/1ps

interface spi_bus_if;

    // first byte of the transaction
    spi_pkg::byte_t address;
    logic address_valid;

    // every later byte
    spi_pkg::byte_t data;
    logic data_valid;

    // high while the host holds select low
    logic selected;

    modport source (
        output address,
        output address_valid,
        output data,
        output data_valid,
        output selected
    );

    modport sink (
        input address,
        input address_valid,
        input data,
        input data_valid,
        input selected
    );

endinterface

//--- rtl/spi_peripheral.sv
////////////////////////////////////////
// SPI mode 0 peripheral
////////////////////////////////////////

`timescale 1ns/1ps

module spi_peripheral (
    input logic clock,
    input logic rst,
    input logic spi_clock,
    input logic spi_select,
    input logic spi_data_in,
    output logic spi_data_out,
    input spi_pkg::byte_t read_data,
    spi_bus_if.source bus
);

    logic [1:0] clock_sync;
    logic [1:0] select_sync;
    logic [1:0] data_sync;
    logic clock_last;
    logic clock_rise;
    logic clock_fall;
    logic deselected;
    spi_pkg::peripheral_state_t state;
    logic [2:0] bit_count;
    logic address_strobe;
    logic data_strobe;
    spi_pkg::byte_t shift_in;
    spi_pkg::byte_t next_byte;
    spi_pkg::byte_t shift_out;
    logic [1:0] load_pipe;

    // two flop synchronisers on all pins
    always_ff @(posedge clock) begin
        if (rst) begin
            clock_sync <= 2'b00;
            select_sync <= 2'b11;
            data_sync <= 2'b00;
            clock_last <= 1'b0;
        end else begin
            clock_sync <= {clock_sync[0], spi_clock};
            select_sync <= {select_sync[0], spi_select};
            data_sync <= {data_sync[0], spi_data_in};
            clock_last <= clock_sync[1];
        end
    end

    assign clock_rise = clock_sync[1] & ~clock_last;
    assign clock_fall = ~clock_sync[1] & clock_last;
    assign deselected = select_sync[1];
    assign next_byte = {shift_in[6:0], data_sync[1]};

    // byte framing
    always_ff @(posedge clock) begin
        if (rst) begin
            state <= spi_pkg::state_idle;
            bit_count <= 3'd0;
            address_strobe <= 1'b0;
            data_strobe <= 1'b0;
        end else begin
            address_strobe <= 1'b0;
            data_strobe <= 1'b0;
            if (deselected) begin
                state <= spi_pkg::state_idle;
                bit_count <= 3'd0;
            end else begin
                if (state == spi_pkg::state_idle) begin
                    state <= spi_pkg::state_address;
                end
                if (clock_rise) begin
                    bit_count <= bit_count + 3'd1;
                    if (bit_count == 3'd7) begin
                        if (state == spi_pkg::state_data) begin
                            data_strobe <= 1'b1;
                        end else begin
                            address_strobe <= 1'b1;
                            state <= spi_pkg::state_data;
                        end
                    end
                end
            end
        end
    end

    // incoming bits and completed bytes
    always_ff @(posedge clock) begin
        if (clock_rise && !deselected) begin
            shift_in <= next_byte;
            if (bit_count == 3'd7) begin
                if (state == spi_pkg::state_data) begin
                    bus.data <= next_byte;
                end else begin
                    bus.address <= next_byte;
                end
            end
        end
    end

    // selector and slot each need a cycle before read_data settles
    always_ff @(posedge clock) begin
        if (rst) begin
            load_pipe <= 2'b00;
            shift_out <= '0;
        end else begin
            load_pipe <= {load_pipe[0], address_strobe | data_strobe};
            if (deselected) begin
                shift_out <= '0;
            end else if (load_pipe[1]) begin
                shift_out <= read_data;
            end else if (clock_fall && bit_count != 3'd0) begin
                // no shift on the falling edge that closes a byte
                shift_out <= {shift_out[6:0], 1'b0};
            end
        end
    end

    assign spi_data_out = shift_out[7];

    assign bus.address_valid = address_strobe;
    assign bus.data_valid = data_strobe;
    assign bus.selected = ~select_sync[1];

    assert property (@(posedge clock) disable iff (rst) !(address_strobe && data_strobe));

endmodule

//--- rtl/spi_pkg.sv
////////////////////////////////////////
// SPI shared types
////////////////////////////////////////

`include "spi_settings.svh"

package spi_pkg;

    // one byte on the SPI link
    typedef logic [7:0] byte_t;

    // byte index inside a scratch slot
    typedef logic [$clog2(`SPI_SLOT_DEPTH)-1:0] slot_pointer_t;

    // slot number taken from the address byte
    typedef logic [$clog2(`SPI_SLOT_COUNT)-1:0] slot_index_t;

    // transaction framing in the peripheral
    typedef enum logic [1:0] {
        state_idle,
        state_address,
        state_data
    } peripheral_state_t;

endpackage

//--- rtl/spi_readback_mux.sv
////////////////////////////////////////
// SPI readback mux
////////////////////////////////////////

`timescale 1ns/1ps

`include "spi_settings.svh"

module spi_readback_mux (
    input spi_pkg::byte_t slot_data [`SPI_SLOT_COUNT],
    input spi_pkg::slot_index_t active_slot,
    input logic [1:0] source_select,
    output spi_pkg::byte_t read_data
);

    always_comb begin
        case (source_select)
            `SPI_SOURCE_SLOT: begin
                read_data = slot_data[active_slot];
            end
            `SPI_SOURCE_CHIP_ID: begin
                read_data = `SPI_CHIP_ID;
            end
            default: begin
                // unknown addresses read as zero
                read_data = '0;
            end
        endcase
    end

endmodule

//--- rtl/spi_scratch_register.sv
////////////////////////////////////////
// SPI scratch register slot
////////////////////////////////////////

`timescale 1ns/1ps

`include "spi_settings.svh"

module spi_scratch_register (
    input logic clock,
    input logic rst,
    input logic start,
    input logic write,
    input logic advance,
    input spi_pkg::byte_t write_data,
    output spi_pkg::byte_t read_data
);

    spi_pkg::byte_t buffer [`SPI_SLOT_DEPTH];
    spi_pkg::slot_pointer_t pointer;

    // pointer wraps at the slot depth
    always_ff @(posedge clock) begin
        if (rst) begin
            pointer <= '0;
            for (int i = 0; i < `SPI_SLOT_DEPTH; i++) begin
                buffer[i] <= '0;
            end
        end else begin
            if (start) begin
                pointer <= '0;
            end else if (write) begin
                buffer[pointer] <= write_data;
                pointer <= pointer + 1'b1;
            end else if (advance) begin
                pointer <= pointer + 1'b1;
            end
        end
    end

    // byte at the pointer, ready for the next load
    assign read_data = buffer[pointer];

    // one transaction is either a write or a read
    assert property (@(posedge clock) disable iff (rst) !(write && advance));

endmodule

//--- rtl/spi_settings.svh
////////////////////////////////////////
// SPI register map settings
////////////////////////////////////////

`ifndef SPI_SETTINGS_SVH
`define SPI_SETTINGS_SVH

// scratch slots and bytes per slot
`define SPI_SLOT_COUNT 4
`define SPI_SLOT_DEPTH 8

// address byte layout
`define SPI_WRITE_BIT 7
`define SPI_CHIP_ID_ADDRESS 8'hdb

// value returned on every chip id byte
`define SPI_CHIP_ID 8'h81

// readback source codes, selector to mux
`define SPI_SOURCE_SLOT 2'd0
`define SPI_SOURCE_CHIP_ID 2'd1
`define SPI_SOURCE_NONE 2'd2

`endif

//--- rtl/spi_subperipheral_selector.sv
////////////////////////////////////////
// SPI address decoder
////////////////////////////////////////

`timescale 1ns/1ps

`include "spi_settings.svh"

module spi_subperipheral_selector (
    input logic clock,
    input logic rst,
    spi_bus_if.sink bus,
    output logic [`SPI_SLOT_COUNT-1:0] slot_start,
    output logic [`SPI_SLOT_COUNT-1:0] slot_write,
    output logic [`SPI_SLOT_COUNT-1:0] slot_advance,
    output spi_pkg::slot_index_t active_slot,
    output logic [1:0] source_select
);

    logic write_mode;
    logic slot_hit;
    spi_pkg::slot_index_t address_index;
    logic [`SPI_SLOT_COUNT-1:0] address_onehot;
    logic [`SPI_SLOT_COUNT-1:0] active_onehot;

    // only the low slot addresses reach a slot, write flag aside
    assign slot_hit = bus.address[`SPI_WRITE_BIT-1:0] < `SPI_SLOT_COUNT;
    assign address_index = spi_pkg::slot_index_t'(bus.address);
    assign address_onehot = {{(`SPI_SLOT_COUNT-1){1'b0}}, 1'b1} << address_index;
    assign active_onehot = {{(`SPI_SLOT_COUNT-1){1'b0}}, 1'b1} << active_slot;

    always_ff @(posedge clock) begin
        if (rst) begin
            write_mode <= 1'b0;
            active_slot <= '0;
            source_select <= `SPI_SOURCE_NONE;
            slot_start <= '0;
            slot_write <= '0;
            slot_advance <= '0;
        end else begin
            slot_start <= '0;
            slot_write <= '0;
            slot_advance <= '0;
            if (!bus.selected) begin
                source_select <= `SPI_SOURCE_NONE;
            end else if (bus.address_valid) begin
                write_mode <= bus.address[`SPI_WRITE_BIT];
                active_slot <= address_index;
                if (bus.address == `SPI_CHIP_ID_ADDRESS) begin
                    source_select <= `SPI_SOURCE_CHIP_ID;
                end else if (slot_hit) begin
                    source_select <= `SPI_SOURCE_SLOT;
                    slot_start <= address_onehot;
                end else begin
                    source_select <= `SPI_SOURCE_NONE;
                end
            end else if (bus.data_valid && source_select == `SPI_SOURCE_SLOT) begin
                if (write_mode) begin
                    slot_write <= active_onehot;
                end else begin
                    slot_advance <= active_onehot;
                end
            end
        end
    end

    assert property (@(posedge clock) disable iff (rst) $onehot0(slot_write));

endmodule

//--- rtl/spi_top.sv
////////////////////////////////////////
// SPI register block top
////////////////////////////////////////

`timescale 1ns/1ps

`include "spi_settings.svh"

module spi_top (
    input logic clock,
    input logic rst,
    input logic spi_clock,
    input logic spi_select,
    input logic spi_data_in,
    output logic spi_data_out
);

    logic [`SPI_SLOT_COUNT-1:0] slot_start;
    logic [`SPI_SLOT_COUNT-1:0] slot_write;
    logic [`SPI_SLOT_COUNT-1:0] slot_advance;
    spi_pkg::slot_index_t active_slot;
    logic [1:0] source_select;
    spi_pkg::byte_t slot_data [`SPI_SLOT_COUNT];
    spi_pkg::byte_t read_data;

    spi_bus_if bus ();

    spi_peripheral spi_peripheral (
        .clock(clock),
        .rst(rst),
        .spi_clock(spi_clock),
        .spi_select(spi_select),
        .spi_data_in(spi_data_in),
        .spi_data_out(spi_data_out),
        .read_data(read_data),
        .bus(bus.source)
    );

    spi_subperipheral_selector spi_subperipheral_selector (
        .clock(clock),
        .rst(rst),
        .bus(bus.sink),
        .slot_start(slot_start),
        .slot_write(slot_write),
        .slot_advance(slot_advance),
        .active_slot(active_slot),
        .source_select(source_select)
    );

    for (genvar i = 0; i < `SPI_SLOT_COUNT; i++) begin : g_slot
        spi_scratch_register spi_scratch_register (
            .clock(clock),
            .rst(rst),
            .start(slot_start[i]),
            .write(slot_write[i]),
            .advance(slot_advance[i]),
            .write_data(bus.data),
            .read_data(slot_data[i])
        );
    end

    spi_readback_mux spi_readback_mux (
        .slot_data(slot_data),
        .active_slot(active_slot),
        .source_select(source_select),
        .read_data(read_data)
    );

endmodule

//--- test/spi_tb.sv
////////////////////////////////////////
// SPI register block testbench
////////////////////////////////////////

`timescale 1ns/1ps

`include "spi_settings.svh"

module spi_tb;

    localparam int HALF_CLOCKS = 4;
    localparam int SPI_PERIOD_NS = 80;
    localparam int RESET_CYCLES = 10;
    localparam int ROUNDS = 24;
    localparam int MAX_BYTES = 13;
    localparam int TRANSACTIONS = 4 + 1 + 2 * ROUNDS + 4 * 5 + 10;
    // every transaction at its longest, plus select setup and gap
    localparam int TRANSACTION_NS = (MAX_BYTES * 8 + 3) * SPI_PERIOD_NS;
    localparam int WATCHDOG_NS = 2 * (RESET_CYCLES * 10 + TRANSACTIONS * TRANSACTION_NS);

    logic clock;
    logic rst;
    logic spi_clock;
    logic spi_select;
    logic spi_data_in;
    logic spi_data_out;

    logic [31:0] lfsr_state;
    spi_pkg::byte_t tx_buffer [16];
    spi_pkg::byte_t rx_buffer [16];
    spi_pkg::byte_t model [`SPI_SLOT_COUNT][`SPI_SLOT_DEPTH];

    spi_top dut (
        .clock(clock),
        .rst(rst),
        .spi_clock(spi_clock),
        .spi_select(spi_select),
        .spi_data_in(spi_data_in),
        .spi_data_out(spi_data_out)
    );

    always #5 clock = ~clock;

    // x^32 + x^22 + x^2 + x + 1
    function automatic logic [31:0] lfsr_next(input logic [31:0] value);
        logic feedback;
        feedback = value[31] ^ value[21] ^ value[1] ^ value[0];
        return {value[30:0], feedback};
    endfunction

    task automatic take_random_bits(input int count, output logic [31:0] value);
        value = '0;
        for (int i = 0; i < count; i++) begin
            lfsr_state = lfsr_next(lfsr_state);
            value = {value[30:0], lfsr_state[0]};
        end
    endtask

    // mode 0, host samples on its own rising edge
    task automatic exchange_byte(input spi_pkg::byte_t sent, output spi_pkg::byte_t received);
        for (int i = 7; i >= 0; i--) begin
            @(negedge clock);
            spi_clock = 1'b0;
            spi_data_in = sent[i];
            repeat (HALF_CLOCKS) @(negedge clock);
            received[i] = spi_data_out;
            spi_clock = 1'b1;
            repeat (HALF_CLOCKS - 1) @(negedge clock);
        end
    endtask

    task automatic run_transaction(input int length);
        @(negedge clock);
        spi_select = 1'b0;
        for (int k = 0; k < length; k++) begin
            exchange_byte(tx_buffer[k], rx_buffer[k]);
        end
        @(negedge clock);
        spi_clock = 1'b0;
        repeat (HALF_CLOCKS) @(negedge clock);
        spi_select = 1'b1;
        repeat (2 * HALF_CLOCKS) @(negedge clock);
    endtask

    // register map as seen from the host
    function automatic spi_pkg::byte_t expected_byte(input spi_pkg::byte_t address, input int index);
        if (address == `SPI_CHIP_ID_ADDRESS) begin
            return `SPI_CHIP_ID;
        end
        if (address < `SPI_SLOT_COUNT) begin
            return model[address][index % `SPI_SLOT_DEPTH];
        end
        return 8'h00;
    endfunction

    task automatic write_bytes(input spi_pkg::byte_t address, input int count);
        logic [31:0] value;
        tx_buffer[0] = address;
        for (int k = 1; k <= count; k++) begin
            take_random_bits(8, value);
            tx_buffer[k] = value[7:0];
            // only 0x80 to 0x83 land in a slot
            if (address[7] && address[6:0] < `SPI_SLOT_COUNT) begin
                model[address[1:0]][(k - 1) % `SPI_SLOT_DEPTH] = value[7:0];
            end
        end
        run_transaction(count + 1);
    endtask

    task automatic check_byte(input string test_name, input int index,
                              input spi_pkg::byte_t expected, input spi_pkg::byte_t actual);
        assert (actual == expected) else begin
            $display("Error: %s byte %0d expected 0x%02h actual 0x%02h",
                     test_name, index, expected, actual);
            $display("Result: FAILED");
            $fatal(1, "read data mismatch");
        end
    endtask

    task automatic read_and_check(input spi_pkg::byte_t address, input int count,
                                  input string test_name);
        logic [31:0] value;
        tx_buffer[0] = address;
        for (int k = 1; k <= count; k++) begin
            take_random_bits(8, value);
            tx_buffer[k] = value[7:0];
        end
        run_transaction(count + 1);
        // first data byte carries pointer 0
        for (int k = 1; k <= count; k++) begin
            check_byte(test_name, k, expected_byte(address, k - 1), rx_buffer[k]);
        end
    endtask

    task automatic pick_unknown_address(output spi_pkg::byte_t address);
        logic [31:0] value;
        take_random_bits(8, value);
        address = value[7:0];
        if (address[6:0] < `SPI_SLOT_COUNT) begin
            address[6:0] = address[6:0] + 7'd4;
        end
        if (address == `SPI_CHIP_ID_ADDRESS) begin
            address = 8'h85;
        end
    endtask

    initial begin
        #(WATCHDOG_NS);
        $display("Error: watchdog expired before all transactions finished");
        $display("Result: FAILED");
        $fatal(1, "timeout");
    end

    initial begin
        logic [31:0] value;
        spi_pkg::byte_t address;
        int slot;
        int length;
        clock = 1'b0;
        rst = 1'b1;
        spi_clock = 1'b0;
        spi_select = 1'b1;
        spi_data_in = 1'b0;
        lfsr_state = 32'hf7aa_8e4d;
        for (int s = 0; s < `SPI_SLOT_COUNT; s++) begin
            for (int b = 0; b < `SPI_SLOT_DEPTH; b++) begin
                model[s][b] = 8'h00;
            end
        end
        repeat (RESET_CYCLES) @(negedge clock);
        rst = 1'b0;
        repeat (4) @(negedge clock);

        for (int s = 0; s < `SPI_SLOT_COUNT; s++) begin
            read_and_check(spi_pkg::byte_t'(s), 8, "reset_clear");
        end

        read_and_check(`SPI_CHIP_ID_ADDRESS, 6, "chip_id");

        // nine byte reads also cover the pointer wrap
        for (int r = 0; r < ROUNDS; r++) begin
            take_random_bits(2, value);
            slot = int'(value[1:0]);
            take_random_bits(4, value);
            length = int'(value[3:0]) % 12 + 1;
            write_bytes(8'h80 | spi_pkg::byte_t'(slot), length);
            read_and_check(spi_pkg::byte_t'(slot), 9, "random_write");
        end

        for (int s = 0; s < `SPI_SLOT_COUNT; s++) begin
            write_bytes(8'h80 | spi_pkg::byte_t'(s), 8);
            for (int r = 0; r < `SPI_SLOT_COUNT; r++) begin
                read_and_check(spi_pkg::byte_t'(r), 8, "slot_isolation");
            end
        end

        write_bytes(8'h85, 8);
        for (int w = 0; w < 2; w++) begin
            pick_unknown_address(address);
            write_bytes(address, 8);
        end
        for (int s = 0; s < `SPI_SLOT_COUNT; s++) begin
            read_and_check(spi_pkg::byte_t'(s), 8, "unknown_write");
        end
        for (int u = 0; u < 3; u++) begin
            pick_unknown_address(address);
            read_and_check(address, 4, "unknown_read");
        end

        $display("Result: PASSED");
        $finish;
    end

endmodule
